//--- include/fire_expand3_consts.svh
`ifndef FIRE_EXPAND3_CONSTS_SVH
`define FIRE_EXPAND3_CONSTS_SVH

// Array geometry, one MAC lane per output channel
`define FE3_NLANE 4
`define FE3_CHIN 2
// 3x3 window over every input channel
`define FE3_NTAP (3 * 3 * `FE3_CHIN)
`define FE3_WOUT 3
`define FE3_NPIX (`FE3_WOUT * `FE3_WOUT)

// Datapath widths
`define FE3_DW 16
`define FE3_AW 32

// Requantize slice of the accumulator
`define FE3_QLSB 14
`define FE3_QMSB 28

// Result vectors held between MAC array and writer
`define FE3_BUF_DEPTH 4

// Synthetic weight rule, kernel = (((L*LSTEP + l*CSTEP + t) mod PERIOD) - MID) * KER_ONE
`define FE3_KER_LSTEP 7
`define FE3_KER_CSTEP 3
`define FE3_KER_PERIOD 9
`define FE3_KER_MID 4
`define FE3_KER_ONE 4096
// Bias = (l + 1 + L) * BIAS_ONE
`define FE3_BIAS_ONE 16384

`endif

//--- src/fire_expand3_pkg.sv
`include "fire_expand3_consts.svh"

package fire_expand3_pkg;

	// 0 selects fire4 and 1 selects fire5
	typedef logic layer_t;

	// Must also hold NTAP itself for the drain slot
	typedef logic [$clog2(`FE3_NTAP + 1)-1:0] tap_idx_t;
	typedef logic [$clog2(`FE3_NPIX)-1:0] pix_idx_t;
	typedef logic [$clog2(`FE3_NPIX * `FE3_NLANE)-1:0] ram_addr_t;

	// Lane vectors from the weight ROM
	typedef logic [`FE3_NLANE-1:0][`FE3_DW-1:0] lane_dw_t;
	typedef logic [`FE3_NLANE-1:0][`FE3_AW-1:0] lane_aw_t;

	// One serial tap from sequencer to MAC array
	typedef struct packed {
		logic                      valid;
		layer_t                    layer;
		tap_idx_t                  tap;
		logic signed [`FE3_DW-1:0] pix;
	} tap_cmd_t;

	// Accumulator word seen whole or split for requantize
	typedef union packed {
		logic signed [`FE3_AW-1:0] raw;
		struct packed {
			logic                            sign;
			logic [`FE3_AW-`FE3_QMSB-3:0]    guard;
			logic [`FE3_QMSB-`FE3_QLSB:0]    payload;
			logic [`FE3_QLSB-1:0]            frac;
		} f;
	} acc_word_u;

	// One finished pixel with all lanes
	typedef struct packed {
		lane_dw_t data;
		layer_t   layer;
		pix_idx_t pix;
	} ofm_vec_t;

	// Single-lane RAM write
	typedef struct packed {
		logic              en;
		layer_t            layer;
		ram_addr_t         addr;
		logic [`FE3_DW-1:0] data;
	} ram_wr_t;

endpackage

//--- src/expand3_sequencer.sv
`include "fire_expand3_consts.svh"

module expand3_sequencer import fire_expand3_pkg::*; (
	input  logic               clk,
	input  logic               rst_gen,
	input  logic               fire4_en,
	input  logic               fire5_en,
	input  logic [`FE3_DW-1:0] ifm,
	input  logic               stall,
	input  logic               layer_written,
	output logic               ifm_take,
	output tap_cmd_t           tap_cmd,
	output logic               acc_clr,
	output logic               layer_busy_done
);

	layer_t   cur_layer;
	tap_idx_t tap_cnt;
	pix_idx_t pix_cnt;
	logic     done;

	logic   active;
	layer_t sel_layer;
	logic   new_layer;
	logic   in_window;
	logic   in_drain;
	logic   drain_exit;

	//////////////////////////////////////////////////////////////////////
	// Layer select and window decode
	//////////////////////////////////////////////////////////////////////

	// fire4 wins when both enables are up
	assign active    = fire4_en | fire5_en;
	assign sel_layer = fire4_en ? 1'b0 : 1'b1;

	// First cycle under a different enable only restarts the counters
	assign new_layer = active && (sel_layer != cur_layer);
	assign in_window = active && !new_layer && !done;

	// Taps 0..NTAP-1 sample the stream, slot NTAP is the drain
	assign ifm_take = in_window && (tap_cnt < tap_idx_t'(`FE3_NTAP));
	assign in_drain = in_window && (tap_cnt == tap_idx_t'(`FE3_NTAP));

	// Held in the drain while the buffer has no room,
	// so the finished sum waits in the accumulators
	assign drain_exit = in_drain && !stall;

	always_comb begin
		tap_cmd.valid = ifm_take;
		tap_cmd.layer = cur_layer;
		tap_cmd.tap   = tap_cnt;
		tap_cmd.pix   = ifm;
	end

	//////////////////////////////////////////////////////////////////////
	// Tap and pixel counters
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst_gen) begin
			cur_layer       <= 1'b0;
			tap_cnt         <= '0;
			pix_cnt         <= '0;
			done            <= 1'b0;
			acc_clr         <= 1'b0;
			layer_busy_done <= 1'b0;
		end else begin
			// Lands one cycle after the drain, as the last tap has just been summed
			acc_clr <= drain_exit;
			if (new_layer) begin
				cur_layer       <= sel_layer;
				tap_cnt         <= '0;
				pix_cnt         <= '0;
				done            <= 1'b0;
				layer_busy_done <= 1'b0;
			end else begin
				if (ifm_take) begin
					tap_cnt <= tap_cnt + 1'b1;
				end else if (drain_exit) begin
					tap_cnt <= '0;
					if (pix_cnt == pix_idx_t'(`FE3_NPIX - 1)) begin
						// All windows issued, stop until the layer changes
						pix_cnt         <= '0;
						done            <= 1'b1;
						layer_busy_done <= 1'b1;
					end else begin
						pix_cnt <= pix_cnt + 1'b1;
					end
				end
				// Writer has finished the layer, drop the busy-done report
				if (done && layer_written) begin
					layer_busy_done <= 1'b0;
				end
			end
		end
	end

endmodule

//--- src/expand3_weight_rom.sv
`include "fire_expand3_consts.svh"

module expand3_weight_rom import fire_expand3_pkg::*; (
	input  layer_t   layer,
	input  tap_idx_t tap,
	output lane_dw_t kernel,
	output lane_aw_t bias
);

	//////////////////////////////////////////////////////////////////////
	// Table rules
	//////////////////////////////////////////////////////////////////////

	// Kernel word for one lane and tap, Q3.12 steps of one
	function automatic logic [`FE3_DW-1:0] kernel_word(
		input int lyr,
		input int lane,
		input int t
	);
		int phase;
		phase = (lyr * `FE3_KER_LSTEP + lane * `FE3_KER_CSTEP + t) % `FE3_KER_PERIOD;
		// Centre the phase so both signs appear
		return `FE3_DW'((phase - `FE3_KER_MID) * `FE3_KER_ONE);
	endfunction

	// Bias is aligned to the accumulator, product scale Q.26
	function automatic logic [`FE3_AW-1:0] bias_word(
		input int lyr,
		input int lane
	);
		int step;
		step = lane + 1 + lyr;
		return `FE3_AW'(step * `FE3_BIAS_ONE);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Lookup
	//////////////////////////////////////////////////////////////////////

	// Pure combinational, address to word without delay
	always_comb begin
		for (int l = 0; l < `FE3_NLANE; l++) begin
			kernel[l] = kernel_word(int'(layer), l, int'(tap));
		end
	end

	// Bias depends on the layer only
	always_comb begin
		for (int l = 0; l < `FE3_NLANE; l++) begin
			bias[l] = bias_word(int'(layer), l);
		end
	end

endmodule

//--- src/expand3_mac_array.sv
`include "fire_expand3_consts.svh"

module expand3_mac_array import fire_expand3_pkg::*; (
	input  logic     clk,
	input  logic     rst_gen,
	input  tap_cmd_t tap_cmd,
	input  lane_dw_t kernel,
	input  lane_aw_t bias,
	input  logic     acc_clr,
	output logic     res_push,
	output ofm_vec_t res_vec
);

	// Tap stage
	logic                      tap_vld_q;
	logic signed [`FE3_DW-1:0] pix_q;
	lane_dw_t                  ker_q;
	lane_aw_t                  bias_q;
	layer_t                    lay_q;

	// Accumulators and pixel tag
	lane_aw_t acc_q;
	pix_idx_t pix_cnt;

	logic signed [`FE3_AW-1:0] prod [`FE3_NLANE];
	acc_word_u                 sum  [`FE3_NLANE];

	//////////////////////////////////////////////////////////////////////
	// Tap register one cycle after issue
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst_gen) begin
			tap_vld_q <= 1'b0;
		end else begin
			tap_vld_q <= tap_cmd.valid;
		end
	end

	always_ff @(posedge clk) begin
		pix_q <= tap_cmd.pix;
		ker_q <= kernel;
		// Bias and layer follow the last real tap
		// Drain cycles keep them
		if (tap_cmd.valid) begin
			bias_q <= bias;
			lay_q  <= tap_cmd.layer;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Multiply and accumulate
	//////////////////////////////////////////////////////////////////////

	// Signed 16x16 into a full 32-bit product
	always_comb begin
		for (int l = 0; l < `FE3_NLANE; l++) begin
			prod[l] = tap_vld_q ? pix_q * $signed(ker_q[l]) : 32'sd0;
		end
	end

	// Sums wrap at 32 bits
	// Clear restarts from the incoming product
	always_ff @(posedge clk) begin
		if (rst_gen) begin
			acc_q   <= '0;
			pix_cnt <= '0;
		end else begin
			for (int l = 0; l < `FE3_NLANE; l++) begin
				acc_q[l] <= (acc_clr ? '0 : acc_q[l]) + prod[l];
			end
			if (acc_clr) begin
				pix_cnt <= (pix_cnt == pix_idx_t'(`FE3_NPIX - 1)) ? '0 : pix_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Bias, ReLU, requantize
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int l = 0; l < `FE3_NLANE; l++) begin
			sum[l].raw = acc_q[l] + bias_q[l];
			// Negative goes to zero
			// Else bits QMSB..QLSB under a zero sign
			res_vec.data[l] = sum[l].f.sign ? '0 : {1'b0, sum[l].f.payload};
		end
		res_vec.layer = lay_q;
		res_vec.pix   = pix_cnt;
	end

	// Vector is complete in the clear cycle
	assign res_push = acc_clr;

endmodule

//--- src/ofm_buffer.sv
`include "fire_expand3_consts.svh"

module ofm_buffer import fire_expand3_pkg::*; #(
	parameter int DEPTH = `FE3_BUF_DEPTH
) (
	input  logic     clk,
	input  logic     rst_gen,
	input  logic     push,
	input  ofm_vec_t din,
	input  logic     pop,
	output ofm_vec_t dout,
	output logic     empty,
	output logic     full
);

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	ofm_vec_t        mem [DEPTH];
	logic [PW-1:0]   wr_ptr;
	logic [PW-1:0]   rd_ptr;
	logic [CW-1:0]   count;

	logic do_push;
	logic do_pop;

	// Requests outside the legal range are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// Storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= din;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Circular pointers and fill count
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst_gen) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leaves the count alone
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// First-word fall-through head
	assign dout  = mem[rd_ptr];
	assign empty = (count == '0);
	assign full  = (count == CW'(DEPTH));

endmodule

//--- src/ofm_writer.sv
`include "fire_expand3_consts.svh"

module ofm_writer import fire_expand3_pkg::*; (
	input  logic     clk,
	input  logic     rst_gen,
	input  ofm_vec_t head,
	input  logic     empty,
	output logic     pop,
	input  logic     ram_busy,
	input  logic     ram_feedback_4,
	input  logic     ram_feedback_5,
	input  logic     layer_busy_done,
	output ram_wr_t  ram_wr,
	output logic     fire4_finish,
	output logic     fire5_finish
);

	logic [$clog2(`FE3_NLANE)-1:0] lane_q;
	logic [1:0]                    end_q;
	logic [1:0]                    fb_q;
	logic                          done_seen;

	logic       issue;
	logic       last_lane;
	logic       last_write;
	logic [1:0] fb_in;

	//////////////////////////////////////////////////////////////////////
	// Lane serializer
	//////////////////////////////////////////////////////////////////////

	// One lane per cycle
	// A busy cycle leaves a hole
	assign issue      = !empty && !ram_busy;
	assign last_lane  = (int'(lane_q) == `FE3_NLANE - 1);
	assign pop        = issue && last_lane;
	assign last_write = pop && (head.pix == pix_idx_t'(`FE3_NPIX - 1));

	always_comb begin
		ram_wr.en    = issue;
		ram_wr.layer = head.layer;
		// pixel * NLANE + lane
		ram_wr.addr  = ram_addr_t'(head.pix * `FE3_NLANE + lane_q);
		ram_wr.data  = head.data[lane_q];
	end

	//////////////////////////////////////////////////////////////////////
	// End of layer and finish handshake
	//////////////////////////////////////////////////////////////////////

	// Indexed by layer with bit 0 for fire4
	assign fb_in = {ram_feedback_5, ram_feedback_4};

	always_ff @(posedge clk) begin
		if (rst_gen) begin
			lane_q    <= '0;
			end_q     <= '0;
			fb_q      <= '0;
			done_seen <= 1'b0;
		end else begin
			if (issue) begin
				lane_q <= last_lane ? '0 : lane_q + 1'b1;
			end
			// Sequencer report can be short
			// Held here until the final write
			if (layer_busy_done) begin
				done_seen <= 1'b1;
			end
			if (last_write && (done_seen || layer_busy_done)) begin
				end_q[head.layer] <= 1'b1;
				done_seen         <= 1'b0;
			end
			// Feedback only counts once the flag is up
			// Sticky until reset
			for (int i = 0; i < 2; i++) begin
				fb_q[i] <= fb_q[i] | (fb_in[i] & end_q[i]);
			end
		end
	end

	assign fire4_finish = end_q[0] & ~fb_q[0];
	assign fire5_finish = end_q[1] & ~fb_q[1];

endmodule

//--- src/fire_expand3_top.sv
`include "fire_expand3_consts.svh"

module fire_expand3_top import fire_expand3_pkg::*; (
	input  logic               clk,
	input  logic               rst_gen,
	input  logic               fire4_en,
	input  logic               fire5_en,
	input  logic [`FE3_DW-1:0] ifm,
	input  logic               ram_busy,
	input  logic               ram_feedback_4,
	input  logic               ram_feedback_5,
	output ram_wr_t            ram_wr,
	output logic               ifm_take,
	output logic               fire4_finish,
	output logic               fire5_finish
);

	tap_cmd_t tap_cmd;
	lane_dw_t kernel;
	lane_aw_t bias;
	ofm_vec_t res_vec;
	ofm_vec_t buf_head;
	logic     acc_clr;
	logic     res_push;
	logic     buf_pop;
	logic     buf_empty;
	logic     buf_full;
	logic     layer_busy_done;
	logic     layer_written;

	// Either finish flag means the writer is through with the layer
	assign layer_written = fire4_finish | fire5_finish;

	//////////////////////////////////////////////////////////////////////
	// Producer side
	//////////////////////////////////////////////////////////////////////

	expand3_sequencer seq_i (
		.clk(clk), .rst_gen(rst_gen),
		.fire4_en(fire4_en), .fire5_en(fire5_en),
		.ifm(ifm), .stall(buf_full), .layer_written(layer_written),
		.ifm_take(ifm_take), .tap_cmd(tap_cmd), .acc_clr(acc_clr),
		.layer_busy_done(layer_busy_done)
	);

	// ROM addressed straight from the issued tap
	expand3_weight_rom rom_i (
		.layer(tap_cmd.layer), .tap(tap_cmd.tap), .kernel(kernel), .bias(bias)
	);

	expand3_mac_array mac_i (
		.clk(clk), .rst_gen(rst_gen), .tap_cmd(tap_cmd),
		.kernel(kernel), .bias(bias), .acc_clr(acc_clr),
		.res_push(res_push), .res_vec(res_vec)
	);

	//////////////////////////////////////////////////////////////////////
	// Buffer and consumer
	//////////////////////////////////////////////////////////////////////

	ofm_buffer buf_i (
		.clk(clk), .rst_gen(rst_gen), .push(res_push), .din(res_vec),
		.pop(buf_pop), .dout(buf_head), .empty(buf_empty), .full(buf_full)
	);

	ofm_writer wr_i (
		.clk(clk), .rst_gen(rst_gen), .head(buf_head), .empty(buf_empty),
		.pop(buf_pop), .ram_busy(ram_busy),
		.ram_feedback_4(ram_feedback_4), .ram_feedback_5(ram_feedback_5),
		.layer_busy_done(layer_busy_done), .ram_wr(ram_wr),
		.fire4_finish(fire4_finish), .fire5_finish(fire5_finish)
	);

endmodule

//--- testbench/fire_expand3_checker.sv
`include "fire_expand3_consts.svh"

module fire_expand3_checker import fire_expand3_pkg::*; (
	input logic    clk,
	input logic    rst_gen,
	input ram_wr_t ram_wr,
	input logic    res_push,
	input logic    buf_full,
	input logic    acc_clr,
	input logic    ifm_take,
	input logic    fire4_finish,
	input logic    fire5_finish
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam ram_addr_t LAST_ADDR = ram_addr_t'(`FE3_NPIX * `FE3_NLANE - 1);

	// Failed assertions so far
	int err_count = 0;

	// Taps sampled since the previous clear
	logic [$clog2(`FE3_NTAP + 2)-1:0] take_cnt;
	// Address the next RAM write must carry
	ram_addr_t                        next_addr;

	always_ff @(posedge clk) begin
		if (rst_gen) begin
			take_cnt  <= '0;
			next_addr <= '0;
		end else begin
			take_cnt <= (acc_clr ? '0 : take_cnt) + ifm_take;
			if (ram_wr.en) begin
				next_addr <= (ram_wr.addr == LAST_ADDR) ? '0 : ram_wr.addr + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Strobes and buffer
	//////////////////////////////////////////////////////////////////////

	// Busy holes neither skip nor repeat a lane
	a_wr_in_order: assert property (@(posedge clk) disable iff (rst_gen)
		ram_wr.en |-> (ram_wr.addr == next_addr))
	else begin
		err_count++;
		$error("ram write address out of sequence");
	end

	// Buffer never overrun
	a_no_push_full: assert property (@(posedge clk) disable iff (rst_gen)
		!(res_push && buf_full))
	else begin
		err_count++;
		$error("result push while ofm buffer is full");
	end

	// Each clear closes a window of exactly NTAP sampled taps
	a_clr_full_window: assert property (@(posedge clk) disable iff (rst_gen)
		acc_clr |-> (take_cnt == `FE3_NTAP))
	else begin
		err_count++;
		$error("acc_clr after a window without NTAP sampled taps");
	end

	//////////////////////////////////////////////////////////////////////
	// Finish follows the last write of its layer
	//////////////////////////////////////////////////////////////////////

	a_fire4_after_last: assert property (@(posedge clk) disable iff (rst_gen)
		$rose(fire4_finish) |-> $past(ram_wr.en && !ram_wr.layer && ram_wr.addr == LAST_ADDR))
	else begin
		err_count++;
		$error("fire4_finish rose without the last fire4 write");
	end

	a_fire5_after_last: assert property (@(posedge clk) disable iff (rst_gen)
		$rose(fire5_finish) |-> $past(ram_wr.en && ram_wr.layer && ram_wr.addr == LAST_ADDR))
	else begin
		err_count++;
		$error("fire5_finish rose without the last fire5 write");
	end

endmodule

bind fire_expand3_top fire_expand3_checker chk_i (
	.clk(clk), .rst_gen(rst_gen), .ram_wr(ram_wr),
	.res_push(res_push), .buf_full(buf_full), .acc_clr(acc_clr), .ifm_take(ifm_take),
	.fire4_finish(fire4_finish), .fire5_finish(fire5_finish)
);

//--- testbench/fire_expand3_tb.sv
`include "fire_expand3_consts.svh"

module fire_expand3_tb import fire_expand3_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NWR       = `FE3_NPIX * `FE3_NLANE;
	localparam int NTAPS_ALL = `FE3_NPIX * `FE3_NTAP;
	localparam int CYC_LIMIT = 4000;
	localparam int NROWS     = 6;

	// One table row
	// Busy mode 0 idle, 1 random, 2 long burst
	typedef struct packed {
		logic       layer;
		logic [7:0] seed_ofs;
		logic [1:0] busy_mode;
		logic [3:0] fb_delay;
	} test_row_t;

	logic               clk;
	logic               rst_gen;
	logic               fire4_en;
	logic               fire5_en;
	logic [`FE3_DW-1:0] ifm;
	logic               ram_busy;
	logic               ram_feedback_4;
	logic               ram_feedback_5;
	ram_wr_t            ram_wr;
	logic               ifm_take;
	logic               fire4_finish;
	logic               fire5_finish;

	test_row_t          rows [NROWS];
	logic [`FE3_DW-1:0] stream [NTAPS_ALL];
	logic [`FE3_DW-1:0] exp_data [NWR];
	integer             seed;
	int                 errors;
	int                 checks;
	int                 tests_failed;

	fire_expand3_top dut_i (.*);

	// 20 ns clock
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Compare and reset helpers
	//////////////////////////////////////////////////////////////////////

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] t=%0t %s: expected %0h, got %0h", $time, name, exp, act);
		end
	endtask

	// 3 cycles of reset and a few quiet idle cycles
	task automatic reset_and_check();
		@(posedge clk);
		#2;
		rst_gen        = 1'b1;
		fire4_en       = 1'b0;
		fire5_en       = 1'b0;
		ifm            = '0;
		ram_busy       = 1'b0;
		ram_feedback_4 = 1'b0;
		ram_feedback_5 = 1'b0;
		repeat (3) @(posedge clk);
		#2;
		rst_gen = 1'b0;
		for (int i = 0; i < 3; i++) begin
			@(negedge clk);
			check_val("ram_wr.en", 32'd0, 32'(ram_wr.en));
			check_val("ifm_take", 32'd0, 32'(ifm_take));
			check_val("fire4_finish", 32'd0, 32'(fire4_finish));
			check_val("fire5_finish", 32'd0, 32'(fire5_finish));
			check_val("acc_clr", 32'd0, 32'(dut_i.acc_clr));
			check_val("res_push", 32'd0, 32'(dut_i.res_push));
			check_val("buf_empty", 32'd1, 32'(dut_i.buf_empty));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus and reference model
	//////////////////////////////////////////////////////////////////////

	// Small signed pixels and their expected outputs from the weight and quantize rules
	task automatic build_test(input test_row_t row, output int zeros);
		logic [31:0]        r;
		logic signed [31:0] acc;
		logic signed [31:0] sum;
		int                 lyr;
		int                 k;
		zeros = 0;
		lyr   = int'(row.layer);
		seed  = 32'h1eab1576 + 32'(row.seed_ofs);
		for (int i = 0; i < NTAPS_ALL; i++) begin
			r = $random(seed);
			// -64 .. 63
			stream[i] = 16'(r[6:0]) - 16'd64;
		end
		for (int p = 0; p < `FE3_NPIX; p++) begin
			for (int l = 0; l < `FE3_NLANE; l++) begin
				acc = '0;
				for (int t = 0; t < `FE3_NTAP; t++) begin
					k   = ((7 * lyr + 3 * l + t) % 9 - 4) * 4096;
					acc = acc + $signed(stream[p * `FE3_NTAP + t]) * k;
				end
				sum = acc + (l + 1 + lyr) * 16384;
				// ReLU before keeping the payload slice
				if (sum[31]) begin
					zeros++;
					exp_data[p * `FE3_NLANE + l] = '0;
				end else begin
					exp_data[p * `FE3_NLANE + l] = {1'b0, sum[`FE3_QMSB:`FE3_QLSB]};
				end
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// One table row with stimulus, write monitor and finish handshake
	//////////////////////////////////////////////////////////////////////

	task automatic run_test(input int idx);
		test_row_t row;
		int        zeros;
		int        err_before;
		int        take_idx;
		int        wr_idx;
		int        cyc;
		int        low_cycles;
		int        last_wr_cyc;
		int        fin_cyc;
		int        fb_cyc;
		logic      fin_seen;
		logic      fb_sent;
		logic      stop;
		logic      my_fin;
		logic      other_fin;
		row        = rows[idx];
		err_before = errors;
		reset_and_check();
		build_test(row, zeros);
		take_idx    = 0;
		wr_idx      = 0;
		cyc         = 0;
		low_cycles  = 0;
		last_wr_cyc = 0;
		fin_cyc     = 0;
		fb_cyc      = 0;
		fin_seen    = 1'b0;
		fb_sent     = 1'b0;
		stop        = 1'b0;
		while (!stop && cyc < CYC_LIMIT) begin
			@(posedge clk);
			#2;
			fire4_en = !row.layer;
			fire5_en = row.layer;
			// Stream holds its word until the DUT takes it
			ifm = (take_idx < NTAPS_ALL) ? stream[take_idx] : '0;
			case (row.busy_mode)
				2'd1:    ram_busy = (($random(seed) & 3) == 0);
				2'd2:    ram_busy = (cyc >= 40 && cyc < 260);
				default: ram_busy = 1'b0;
			endcase
			ram_feedback_4 = 1'b0;
			ram_feedback_5 = 1'b0;
			if (fin_seen && !fb_sent && cyc >= fin_cyc + 1 + int'(row.fb_delay)) begin
				fb_sent = 1'b1;
				fb_cyc  = cyc;
				ram_feedback_4 = !row.layer;
				ram_feedback_5 = row.layer;
			end
			@(negedge clk);
			if (ifm_take) begin
				if (take_idx >= NTAPS_ALL) begin
					errors++;
					$display("[ERROR] t=%0t ifm_take high after the last tap of the layer", $time);
				end
				take_idx++;
			end else if (take_idx < NTAPS_ALL) begin
				low_cycles++;
			end
			// Write monitor
			// Writes arrive in address order
			if (ram_wr.en) begin
				if (wr_idx >= NWR) begin
					errors++;
					$display("[ERROR] t=%0t extra RAM write beyond the layer", $time);
				end else begin
					check_val("ram_wr.layer", 32'(row.layer), 32'(ram_wr.layer));
					check_val("ram_wr.addr", 32'(wr_idx), 32'(ram_wr.addr));
					check_val("ram_wr.data", 32'(exp_data[wr_idx]), 32'(ram_wr.data));
				end
				wr_idx++;
				last_wr_cyc = cyc;
			end
			my_fin    = row.layer ? fire5_finish : fire4_finish;
			other_fin = row.layer ? fire4_finish : fire5_finish;
			check_val("other layer finish", 32'd0, 32'(other_fin));
			if (!fin_seen) begin
				if (my_fin) begin
					fin_seen = 1'b1;
					fin_cyc  = cyc;
					check_val("writes before finish", 32'(NWR), 32'(wr_idx));
					check_val("finish cycle", 32'(last_wr_cyc + 1), 32'(cyc));
				end
			end else begin
				// High until the pulse is registered and low for good after
				check_val(row.layer ? "fire5_finish" : "fire4_finish",
					32'(!fb_sent || cyc == fb_cyc), 32'(my_fin));
				if (fb_sent && cyc == fb_cyc + 3) begin
					stop = 1'b1;
				end
			end
			cyc++;
		end
		if (!stop) begin
			errors++;
			$display("[ERROR] t=%0t test %0d timed out before finish and feedback (%0d writes)",
				$time, idx, wr_idx);
		end
		// Drain slots plus the layer switch
		// More only when the buffer backed up
		if (row.busy_mode == 2'd2) begin
			check_val("stall seen", 32'd1, 32'(low_cycles > `FE3_NPIX - 1 + int'(row.layer)));
		end else begin
			check_val("idle take cycles", 32'(`FE3_NPIX - 1 + int'(row.layer)), 32'(low_cycles));
		end
		if (errors != err_before) begin
			tests_failed++;
		end
		$display("test %0d fire%0d busy mode %0d: %s, %0d writes, %0d relu zeros, %0d cycles",
			idx, 4 + int'(row.layer), row.busy_mode,
			(errors == err_before) ? "ok" : "FAILED", wr_idx, zeros, cyc);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		rst_gen        = 1'b1;
		fire4_en       = 1'b0;
		fire5_en       = 1'b0;
		ifm            = '0;
		ram_busy       = 1'b0;
		ram_feedback_4 = 1'b0;
		ram_feedback_5 = 1'b0;
		errors         = 0;
		checks         = 0;
		tests_failed   = 0;
		seed           = 32'h1eab1576;
		// layer, seed offset, busy mode, feedback delay
		rows[0] = '{1'b0, 8'd0, 2'd0, 4'd2};
		rows[1] = '{1'b1, 8'd1, 2'd0, 4'd4};
		rows[2] = '{1'b0, 8'd2, 2'd1, 4'd1};
		rows[3] = '{1'b1, 8'd3, 2'd1, 4'd0};
		rows[4] = '{1'b1, 8'd4, 2'd2, 4'd3};
		rows[5] = '{1'b0, 8'd5, 2'd2, 4'd6};
		for (int i = 0; i < NROWS; i++) begin
			run_test(i);
		end
		check_val("checker assertion failures", 32'd0, 32'(dut_i.chk_i.err_count));
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			NROWS, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- fire_expand3.f
+incdir+include
src/fire_expand3_pkg.sv
src/expand3_sequencer.sv
src/expand3_weight_rom.sv
src/expand3_mac_array.sv
src/ofm_buffer.sv
src/ofm_writer.sv
src/fire_expand3_top.sv
testbench/fire_expand3_checker.sv
testbench/fire_expand3_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator and run; the result is read from the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f fire_expand3.f \
	--top-module fire_expand3_tb -o fe3_sim || { echo "run_sim: build error"; exit 1; }
out=$(./obj_dir/fe3_sim)
echo "$out"
echo "$out" | grep -qx "Simulation passed" && echo "run_sim: PASS" || {
	echo "run_sim: FAIL"
	exit 1
}
